// File: hdl/neuron_defs.svh
`ifndef NEURON_DEFS_SVH
`define NEURON_DEFS_SVH

// Single precision layout
`define FLOAT_W 32
`define EXP_W 8
`define MANT_W (`FLOAT_W - `EXP_W - 1)

// Layer shape and pipeline depth
`define IN_COUNT 10
`define NODE_COUNT 2
`define NODE_LATENCY 2

// Weight rows, feature 9 first and feature 0 in the low word
`define NODE0_WEIGHTS { \
	32'h3F00_0000, 32'hC000_0000, 32'h3F80_0000, 32'h3F80_0000, 32'hBF00_0000, \
	32'h3E80_0000, 32'h4000_0000, 32'hBF80_0000, 32'h3F80_0000, 32'h3F00_0000 }

`define NODE1_WEIGHTS { \
	32'hBF80_0000, 32'h4000_0000, 32'h3E80_0000, 32'hBF00_0000, 32'h3F80_0000, \
	32'h3F80_0000, 32'hC000_0000, 32'h3F00_0000, 32'h3E80_0000, 32'hBF80_0000 }

// 1.0 and -0.5
`define NODE0_BIAS 32'h3F80_0000
`define NODE1_BIAS 32'hBF00_0000

`endif

// File: hdl/neuronPkg.sv
`include "neuron_defs.svh"

package neuronPkg;

	typedef logic [`EXP_W-1:0] expT;
	typedef logic [`MANT_W-1:0] mantT;

	// Sign, biased exponent, fraction
	typedef struct packed
	{
		logic sign;
		expT exponent;
		mantT mantissa;
	} floatT;

	// Feature 0 sits in the low word
	typedef floatT [`IN_COUNT-1:0] featureVecT;

	// One activation per neuron
	typedef floatT [`NODE_COUNT-1:0] layerOutT;

endpackage

// File: hdl/floatMult.sv
module floatMult
	import neuronPkg::*;
(
	input floatT a,
	input floatT b,
	output floatT product
);

	localparam int expW = $bits(expT);
	localparam int mantW = $bits(mantT);
	localparam int sigW = mantW + 1;
	localparam int expBias = (1 << (expW - 1)) - 1;
	localparam int expMax = (1 << expW) - 1;
	localparam logic signed [expW+1:0] expFloor = (expW + 2)'(0);
	localparam logic signed [expW+1:0] expCeil = (expW + 2)'(expMax);

	logic sign;
	logic zeroIn;
	logic [sigW-1:0] sigA;
	logic [sigW-1:0] sigB;
	logic [2*sigW-1:0] sigProd;
	logic signed [expW+1:0] expSum;
	logic signed [expW+1:0] expNorm;
	mantT mantNorm;

	assign sign = a.sign ^ b.sign;

	// Subnormals are flushed, so a zero exponent means zero
	assign zeroIn = (a.exponent == '0) || (b.exponent == '0);

	assign sigA = {1'b1, a.mantissa};
	assign sigB = {1'b1, b.mantissa};
	assign sigProd = (2 * sigW)'(sigA) * (2 * sigW)'(sigB);

	// Two biased exponents carry the bias twice
	assign expSum = $signed({2'b00, a.exponent}) + $signed({2'b00, b.exponent})
		- (expW + 2)'(expBias);

	// ####################
	// Normalize

	// Product of two significands lies in [1,4)
	always_comb
	begin
		if (sigProd[2*sigW-1])
		begin
			expNorm = expSum + (expW + 2)'(1);
			mantNorm = sigProd[2*sigW-2 -: mantW];
		end
		else
		begin
			expNorm = expSum;
			mantNorm = sigProd[2*sigW-3 -: mantW];
		end
	end

	// ####################
	// Pack result

	always_comb
	begin
		product.sign = sign;
		if (zeroIn || (expNorm <= expFloor))
		begin
			product.exponent = '0;
			product.mantissa = '0;
		end
		else if (expNorm >= expCeil)
		begin
			// Largest finite value
			product.exponent = expT'(expMax - 1);
			product.mantissa = '1;
		end
		else
		begin
			product.exponent = expNorm[expW-1:0];
			product.mantissa = mantNorm;
		end
	end

endmodule

// File: hdl/floatAdd.sv
module floatAdd
	import neuronPkg::*;
(
	input floatT a,
	input floatT b,
	output floatT sum
);

	localparam int expW = $bits(expT);
	localparam int mantW = $bits(mantT);
	localparam int sigW = mantW + 1;
	localparam int guardW = 3;
	localparam int wideW = sigW + guardW;
	localparam int lzW = $clog2(wideW + 1);
	localparam int expMax = (1 << expW) - 1;
	localparam logic signed [expW+1:0] expFloor = (expW + 2)'(0);
	localparam logic signed [expW+1:0] expCeil = (expW + 2)'(expMax);

	logic swap;
	logic subtract;
	floatT big;
	floatT smaller;
	logic [expW-1:0] expDiff;
	logic [wideW-1:0] sigBig;
	logic [wideW-1:0] sigSmallRaw;
	logic [wideW-1:0] sigSmall;
	logic [wideW:0] rawSum;
	logic [lzW-1:0] lz;
	logic [wideW-1:0] normShift;
	logic signed [expW+1:0] expNorm;
	mantT mantNorm;

	// Leading zeros above the first one
	function automatic logic [lzW-1:0] leadZeros(input logic [wideW-1:0] value);
		logic [lzW-1:0] count;
		count = lzW'(wideW);
		for (int i = 0; i < wideW; i++)
		begin
			if (value[i])
				count = lzW'(wideW - 1 - i);
		end
		return count;
	endfunction

	// ####################
	// Align

	// Larger magnitude first
	// Exponent and fraction compare as one integer
	assign swap = {b.exponent, b.mantissa} > {a.exponent, a.mantissa};
	assign big = swap ? b : a;
	assign smaller = swap ? a : b;
	assign subtract = a.sign ^ b.sign;
	assign expDiff = big.exponent - smaller.exponent;

	// Flushed operands carry an empty significand
	assign sigBig = (big.exponent == '0) ? '0 : {1'b1, big.mantissa, {guardW{1'b0}}};
	assign sigSmallRaw = (smaller.exponent == '0) ? '0 :
		{1'b1, smaller.mantissa, {guardW{1'b0}}};

	// Shifts past the width leave nothing
	assign sigSmall = sigSmallRaw >> expDiff;

	// ####################
	// Add and normalize

	// Big is never smaller, so the difference stays non-negative
	assign rawSum = subtract ? ({1'b0, sigBig} - {1'b0, sigSmall}) :
		({1'b0, sigBig} + {1'b0, sigSmall});

	assign lz = leadZeros(rawSum[wideW-1:0]);
	assign normShift = rawSum[wideW-1:0] << lz;

	always_comb
	begin
		if (rawSum[wideW])
		begin
			// Carry out shifts one place right
			expNorm = $signed({2'b00, big.exponent}) + (expW + 2)'(1);
			mantNorm = rawSum[wideW-1 -: mantW];
		end
		else
		begin
			expNorm = $signed({2'b00, big.exponent})
				- $signed({{(expW + 2 - lzW){1'b0}}, lz});
			mantNorm = normShift[wideW-2 -: mantW];
		end
	end

	// ####################
	// Pack result

	always_comb
	begin
		if (rawSum == '0)
		begin
			// Exact cancellation is +0
			sum.sign = 1'b0;
			sum.exponent = '0;
			sum.mantissa = '0;
		end
		else if (expNorm <= expFloor)
		begin
			sum.sign = big.sign;
			sum.exponent = '0;
			sum.mantissa = '0;
		end
		else if (expNorm >= expCeil)
		begin
			sum.sign = big.sign;
			sum.exponent = expT'(expMax - 1);
			sum.mantissa = '1;
		end
		else
		begin
			sum.sign = big.sign;
			sum.exponent = expNorm[expW-1:0];
			sum.mantissa = mantNorm;
		end
	end

endmodule

// File: hdl/neuronNode.sv
`include "neuron_defs.svh"

module neuronNode
	import neuronPkg::*;
#(
	parameter featureVecT weights = '0,
	parameter floatT bias = '0
)
(
	input logic clk,
	input logic arstN,
	input logic inStrobe,
	input featureVecT features,
	output logic outValid,
	output floatT activation
);

	featureVecT products;
	featureVecT productsQ;
	logic productsValid;
	floatT [`IN_COUNT/2-1:0] pairSum;
	floatT frontSum;
	floatT middleSum;
	floatT tailSum;
	floatT headSum;
	floatT treeSum;
	floatT reluOut;

	// ####################
	// Multiply stage

	for (genvar i = 0; i < `IN_COUNT; i++)
	begin : multGen
		floatMult mult_i
		(
			.a(features[i]),
			.b(weights[i]),
			.product(products[i])
		);
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			productsValid <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			productsValid <= inStrobe;
			outValid <= productsValid;
		end
	end

	// Payload only moves with its valid bit
	always_ff @(posedge clk)
	begin
		if (inStrobe)
			productsQ <= products;
		if (productsValid)
			activation <= reluOut;
	end

	// ####################
	// Adder tree

	for (genvar i = 0; i < `IN_COUNT/2; i++)
	begin : pairGen
		floatAdd add_i
		(
			.a(productsQ[2*i]),
			.b(productsQ[2*i+1]),
			.sum(pairSum[i])
		);
	end

	floatAdd front_i
	(
		.a(pairSum[0]),
		.b(pairSum[1]),
		.sum(frontSum)
	);

	floatAdd middle_i
	(
		.a(pairSum[2]),
		.b(pairSum[3]),
		.sum(middleSum)
	);

	// Bias joins the last pair
	floatAdd tail_i
	(
		.a(pairSum[4]),
		.b(bias),
		.sum(tailSum)
	);

	floatAdd head_i
	(
		.a(frontSum),
		.b(middleSum),
		.sum(headSum)
	);

	floatAdd root_i
	(
		.a(headSum),
		.b(tailSum),
		.sum(treeSum)
	);

	// ReLU clears negative zero too
	assign reluOut = treeSum.sign ? '0 : treeSum;

	// ####################
	// Checks

	// Non-negative, finite, and zero whenever the exponent is zero
	activationNonNegative: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> !activation.sign && (activation.exponent != '1)
			&& ((activation.exponent != '0) || (activation.mantissa == '0)));

	strobeGivesValid: assert property (@(posedge clk) disable iff (!arstN)
		inStrobe |-> ##`NODE_LATENCY outValid);

	validHasStrobe: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> $past(inStrobe, `NODE_LATENCY));

endmodule

// File: hdl/denseLayer.sv
`include "neuron_defs.svh"

module denseLayer
	import neuronPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic inStrobe,
	input featureVecT features,
	output logic outValid,
	output layerOutT activations
);

	// Both neurons see the same vector and strobe
	neuronNode #(
		.weights(`NODE0_WEIGHTS),
		.bias(`NODE0_BIAS)
	) node0_i
	(
		.clk(clk),
		.arstN(arstN),
		.inStrobe(inStrobe),
		.features(features),
		.outValid(outValid),
		.activation(activations[0])
	);

	// Same timing as neuron 0, its valid is not needed
	neuronNode #(
		.weights(`NODE1_WEIGHTS),
		.bias(`NODE1_BIAS)
	) node1_i
	(
		.clk(clk),
		.arstN(arstN),
		.inStrobe(inStrobe),
		.features(features),
		.outValid(),
		.activation(activations[1])
	);

endmodule

// File: tests/denseLayerTb.sv
`include "neuron_defs.svh"

module denseLayerTb
	import neuronPkg::*;
();

	localparam int driveDelay = 2;
	localparam int waitLimit = 20;

	// Weights and biases in quarter units, feature 0 first
	localparam int node0WeightQ [`IN_COUNT] = '{2, 4, -4, 8, 1, -2, 4, 4, -8, 2};
	localparam int node1WeightQ [`IN_COUNT] = '{-4, 1, 2, -8, 4, 4, -2, 1, 8, -4};
	localparam int node0BiasQ = 4;
	localparam int node1BiasQ = -2;

	logic clk;
	logic arstN;
	logic inStrobe;
	featureVecT features;
	logic outValid;
	layerOutT activations;

	int seed;
	int featVal [`IN_COUNT];
	int strobeCount;
	int resultCount;
	logic [1:0] expValid = '0;
	layerOutT expAct [2];

	denseLayer dut_i
	(
		.clk(clk),
		.arstN(arstN),
		.inStrobe(inStrobe),
		.features(features),
		.outValid(outValid),
		.activations(activations)
	);

	always #4 clk = ~clk;

	// Exact float word for q/4
	function automatic floatT encodeQuarter(input int q);
		floatT f;
		int mag;
		int msb;
		f = '0;
		mag = (q < 0) ? -q : q;
		msb = 0;
		for (int i = 0; i < 24; i++)
		begin
			if ((mag >> i) & 1)
				msb = i;
		end
		if (q != 0)
		begin
			f.sign = (q < 0);
			f.exponent = 8'(127 + msb - 2);
			f.mantissa = 23'(mag << (23 - msb));
		end
		return f;
	endfunction

	function automatic layerOutT expectedOut(input int f [`IN_COUNT]);
		layerOutT result;
		int sum0;
		int sum1;
		sum0 = node0BiasQ;
		sum1 = node1BiasQ;
		for (int i = 0; i < `IN_COUNT; i++)
		begin
			sum0 += node0WeightQ[i] * f[i];
			sum1 += node1WeightQ[i] * f[i];
		end
		// ReLU, zero and below give the all-zero word
		result[0] = (sum0 > 0) ? encodeQuarter(sum0) : '0;
		result[1] = (sum1 > 0) ? encodeQuarter(sum1) : '0;
		return result;
	endfunction

	task automatic reportMismatch(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "Output check failed");
	endtask

	task automatic reportStall(input string msg);
		$display("Regression failed");
		$fatal(1, "%s", msg);
	endtask

	// ####################
	// Reference model

	// Two stages, same depth as the DUT pipeline
	always @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			expValid <= '0;
			resultCount <= 0;
		end
		else
		begin
			expValid <= {expValid[0], inStrobe};
			if (inStrobe)
				expAct[0] <= expectedOut(featVal);
			expAct[1] <= expAct[0];
			if (outValid)
				resultCount <= resultCount + 1;
		end
	end

	validMatches: assert property (@(posedge clk) outValid == expValid[1])
		else reportMismatch($sformatf("outValid is %0b, expected %0b",
			$sampled(outValid), $sampled(expValid[1])));

	node0Matches: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> activations[0] == expAct[1][0])
		else reportMismatch($sformatf("neuron 0 gave %h, expected %h",
			$sampled(activations[0]), $sampled(expAct[1][0])));

	node1Matches: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> activations[1] == expAct[1][1])
		else reportMismatch($sformatf("neuron 1 gave %h, expected %h",
			$sampled(activations[1]), $sampled(expAct[1][1])));

	// ####################
	// Stimulus

	task automatic nextCycle();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic applyVector(input int f [`IN_COUNT]);
		for (int i = 0; i < `IN_COUNT; i++)
		begin
			featVal[i] = f[i];
			features[i] = encodeQuarter(4 * f[i]);
		end
		inStrobe = 1'b1;
		strobeCount++;
		nextCycle();
	endtask

	task automatic endBurst();
		int count;
		count = 0;
		inStrobe = 1'b0;
		while (resultCount < strobeCount && count < waitLimit)
		begin
			nextCycle();
			count++;
		end
		if (resultCount < strobeCount)
			reportStall("Timed out waiting for outValid after a strobe");
	endtask

	task automatic randomBurst(input int length);
		int f [`IN_COUNT];
		for (int n = 0; n < length; n++)
		begin
			for (int i = 0; i < `IN_COUNT; i++)
				f[i] = $random(seed) % 9;
			applyVector(f);
		end
		endBurst();
	endtask

	// One feature set, all others zero
	task automatic singleFeature(input int index, input int value);
		int f [`IN_COUNT];
		for (int i = 0; i < `IN_COUNT; i++)
			f[i] = 0;
		f[index] = value;
		applyVector(f);
		endBurst();
	endtask

	initial
	begin
		clk = 1'b0;
		arstN = 1'b0;
		inStrobe = 1'b0;
		features = '0;
		seed = 32'h5c8e8c1a;
		strobeCount = 0;
		for (int i = 0; i < `IN_COUNT; i++)
			featVal[i] = 0;

		repeat (5) @(posedge clk);
		#driveDelay;
		arstN = 1'b1;
		repeat (4) nextCycle();

		// Bias only, then one neuron negative at a time, then cancellation
		singleFeature(0, 0);
		singleFeature(8, 3);
		singleFeature(3, 2);
		singleFeature(2, 1);

		repeat (8) randomBurst(1);
		randomBurst(2);
		randomBurst(3);
		randomBurst(6);
		randomBurst(12);
		repeat (4) nextCycle();

		if (resultCount == strobeCount)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			reportStall("Result count does not match strobe count");
	end

endmodule

// File: all.f
+incdir+hdl
hdl/neuronPkg.sv
hdl/floatMult.sv
hdl/floatAdd.sv
hdl/neuronNode.sv
hdl/denseLayer.sv
tests/denseLayerTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run, exit status is the verdict
cd "$(dirname "$0")" \
	&& verilator --binary --assert -Wno-fatal -f all.f --top-module denseLayerTb -o denseLayerTb \
	&& ./obj_dir/denseLayerTb \
	|| exit 1
